// ==== src.f ====
hdl/csr_pkg.sv
hdl/pipe_pkg.sv
hdl/csr_req_port.sv
hdl/csr_check_stage.sv
hdl/csr_file_stage.sv
hdl/csr_unit_top.sv
testbench/csr_unit_checker.sv
testbench/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module csr_unit_tb -o csr_unit_sim -f src.f

./obj_dir/csr_unit_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation stopped before reaching a verdict"
    exit 1
fi

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int NUM_ROWS   = 26;
    localparam int WAIT_LIMIT = 20;

    typedef struct {
        string              name;
        pipe_pkg::csr_req_t req;
        logic               mtip;
        csr_pkg::xlen_t     rdata;
        logic               trap;
        csr_pkg::xlen_t     next_pc;
        csr_pkg::priv_e     priv;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               req;
    pipe_pkg::csr_req_t cmd;
    logic               ack;
    pipe_pkg::csr_rsp_t rsp;
    logic               mtip;

    row_t               stim_table [NUM_ROWS];
    int                 row_count;
    pipe_pkg::csr_rsp_t got;

    csr_unit_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .rsp   (rsp),
        .mtip  (mtip)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input csr_pkg::xlen_t expected,
                              input csr_pkg::xlen_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_priv(input string name, input csr_pkg::priv_e expected,
                              input csr_pkg::priv_e actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s: expected %s, actual %s",
                                     name, expected.name(), actual.name()));
        end
    endtask

    task automatic add_row(input string name, input csr_pkg::csr_cmd_e op_cmd,
                           input csr_pkg::csr_addr_t op_addr, input csr_pkg::xlen_t operand,
                           input csr_pkg::xlen_t pc, input logic irq,
                           input csr_pkg::xlen_t rdata, input logic trap,
                           input csr_pkg::xlen_t next_pc, input csr_pkg::priv_e priv);
        stim_table[row_count].name    = name;
        stim_table[row_count].req     = '{cmd: op_cmd, addr: op_addr, operand: operand, pc: pc};
        stim_table[row_count].mtip    = irq;
        stim_table[row_count].rdata   = rdata;
        stim_table[row_count].trap    = trap;
        stim_table[row_count].next_pc = next_pc;
        stim_table[row_count].priv    = priv;
        row_count++;
    endtask

    // Expected values follow the CSR file rules step by step
    task automatic fill_table();
        add_row("w_mscratch", csr_pkg::CSR_W, 12'h340, 32'h0000_f0f0, 32'h1000, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_1004, csr_pkg::M_MODE);
        add_row("s_mscratch", csr_pkg::CSR_S, 12'h340, 32'h0000_0f0f, 32'h1004, 1'b0,
                32'h0000_f0f0, 1'b0, 32'h0000_1008, csr_pkg::M_MODE);
        add_row("c_mscratch", csr_pkg::CSR_C, 12'h340, 32'h0000_00ff, 32'h1008, 1'b0,
                32'h0000_ffff, 1'b0, 32'h0000_100c, csr_pkg::M_MODE);
        add_row("w_misa", csr_pkg::CSR_W, 12'h301, 32'h0000_0000, 32'h100c, 1'b0,
                32'h4000_1101, 1'b0, 32'h0000_1010, csr_pkg::M_MODE);
        add_row("rd_misa", csr_pkg::CSR_S, 12'h301, 32'h0000_0000, 32'h1010, 1'b0,
                32'h4000_1101, 1'b0, 32'h0000_1014, csr_pkg::M_MODE);
        add_row("w_mtvec", csr_pkg::CSR_W, 12'h305, 32'h0000_0100, 32'h1014, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_1018, csr_pkg::M_MODE);
        // ECALL from M followed by mcause and mepc reads
        add_row("ecall_m", csr_pkg::CSR_ECALL, 12'h000, 32'h0, 32'h1018, 1'b0,
                32'h0000_0000, 1'b1, 32'h0000_0100, csr_pkg::M_MODE);
        add_row("rd_mcause_ecall_m", csr_pkg::CSR_S, 12'h342, 32'h0, 32'h0100, 1'b0,
                32'h0000_000b, 1'b0, 32'h0000_0104, csr_pkg::M_MODE);
        add_row("rd_mepc", csr_pkg::CSR_S, 12'h341, 32'h0, 32'h0104, 1'b0,
                32'h0000_1018, 1'b0, 32'h0000_0108, csr_pkg::M_MODE);
        // MPP was M after the trap
        add_row("w_mstatus", csr_pkg::CSR_W, 12'h300, 32'h0, 32'h0108, 1'b0,
                32'h0000_1800, 1'b0, 32'h0000_010c, csr_pkg::M_MODE);
        add_row("mret_to_u", csr_pkg::CSR_MRET, 12'h000, 32'h0, 32'h010c, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_1018, csr_pkg::U_MODE);
        add_row("w_mscratch_in_u", csr_pkg::CSR_W, 12'h340, 32'h0000_1234, 32'h1018, 1'b0,
                32'h0000_ff00, 1'b1, 32'h0000_0100, csr_pkg::M_MODE);
        add_row("rd_mcause_illegal", csr_pkg::CSR_S, 12'h342, 32'h0, 32'h0100, 1'b0,
                32'h0000_0002, 1'b0, 32'h0000_0104, csr_pkg::M_MODE);
        add_row("rd_mstatus", csr_pkg::CSR_S, 12'h300, 32'h0, 32'h0104, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_0108, csr_pkg::M_MODE);
        // ECALL and MRET issued from U
        add_row("mret_to_u_again", csr_pkg::CSR_MRET, 12'h000, 32'h0, 32'h0108, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_1018, csr_pkg::U_MODE);
        add_row("ecall_u", csr_pkg::CSR_ECALL, 12'h000, 32'h0, 32'h1018, 1'b0,
                32'h0000_0000, 1'b1, 32'h0000_0100, csr_pkg::M_MODE);
        add_row("rd_mcause_ecall_u", csr_pkg::CSR_S, 12'h342, 32'h0, 32'h0100, 1'b0,
                32'h0000_0008, 1'b0, 32'h0000_0104, csr_pkg::M_MODE);
        add_row("mret_back_to_u", csr_pkg::CSR_MRET, 12'h000, 32'h0, 32'h0104, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_1018, csr_pkg::U_MODE);
        add_row("mret_in_u", csr_pkg::CSR_MRET, 12'h000, 32'h0, 32'h1018, 1'b0,
                32'h0000_0000, 1'b1, 32'h0000_0100, csr_pkg::M_MODE);
        add_row("rd_mcause_mret_u", csr_pkg::CSR_S, 12'h342, 32'h0, 32'h0100, 1'b0,
                32'h0000_0002, 1'b0, 32'h0000_0104, csr_pkg::M_MODE);
        // Timer interrupt with vectored mtvec
        add_row("w_mie", csr_pkg::CSR_W, 12'h304, 32'h0000_0080, 32'h0104, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_0108, csr_pkg::M_MODE);
        add_row("w_mtvec_vectored", csr_pkg::CSR_W, 12'h305, 32'h0000_0201, 32'h0108, 1'b0,
                32'h0000_0100, 1'b0, 32'h0000_010c, csr_pkg::M_MODE);
        add_row("no_irq_in_m", csr_pkg::CSR_S, 12'h340, 32'h0, 32'h010c, 1'b1,
                32'h0000_ff00, 1'b0, 32'h0000_0110, csr_pkg::M_MODE);
        add_row("mret_before_irq", csr_pkg::CSR_MRET, 12'h000, 32'h0, 32'h0110, 1'b0,
                32'h0000_0000, 1'b0, 32'h0000_1018, csr_pkg::U_MODE);
        add_row("irq_in_u", csr_pkg::CSR_NOP, 12'h000, 32'h0, 32'h1018, 1'b1,
                32'h0000_0000, 1'b1, 32'h0000_021c, csr_pkg::M_MODE);
        add_row("rd_mcause_irq", csr_pkg::CSR_S, 12'h342, 32'h0, 32'h021c, 1'b0,
                32'h8000_0007, 1'b0, 32'h0000_0220, csr_pkg::M_MODE);
    endtask

    // One full four-phase exchange with req held longer on some rows
    task automatic run_handshake(input int idx, output pipe_pkg::csr_rsp_t result);
        int waited;
        @(negedge clk);
        cmd  = stim_table[idx].req;
        mtip = stim_table[idx].mtip;
        req  = 1'b1;
        waited = 0;
        while (!ack) begin
            if (waited == WAIT_LIMIT) begin
                report_failure($sformatf("Timeout: no ack for row %s", stim_table[idx].name));
            end
            @(negedge clk);
            waited++;
        end
        repeat (idx % 3) @(negedge clk);
        result = rsp;
        req    = 1'b0;
        waited = 0;
        while (ack) begin
            if (waited == WAIT_LIMIT) begin
                report_failure($sformatf("Timeout: ack stuck high for row %s",
                                         stim_table[idx].name));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        cmd       = '0;
        mtip      = 1'b0;
        row_count = 0;
        fill_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < row_count; i++) begin
            run_handshake(i, got);
            check_word({stim_table[i].name, " rdata"}, stim_table[i].rdata, got.rdata);
            check_flag({stim_table[i].name, " trap"}, stim_table[i].trap, got.trap);
            check_word({stim_table[i].name, " next_pc"}, stim_table[i].next_pc, got.next_pc);
            check_priv({stim_table[i].name, " priv"}, stim_table[i].priv, got.priv);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== testbench/csr_unit_checker.sv ====
`timescale 1ns/1ps

module csr_unit_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               req,
    input logic               ack,
    input pipe_pkg::csr_rsp_t rsp
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending request");

    // ack stays up until req is seen low
    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    // Response frozen for the whole ack phase
    rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(rsp))
        else $error("rsp changed while ack was high");

endmodule

bind csr_unit_top csr_unit_checker checker_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .rsp   (rsp)
);

// ==== hdl/csr_unit_top.sv ====
`timescale 1ns/1ps

module csr_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  pipe_pkg::csr_req_t cmd,
    output logic               ack,
    output pipe_pkg::csr_rsp_t rsp,
    input  logic               mtip
);

    logic               issue_valid;
    pipe_pkg::csr_req_t issue_req;
    pipe_pkg::checked_t checked;
    csr_pkg::priv_e     cur_priv;
    logic               done;
    pipe_pkg::csr_rsp_t done_rsp;

    // Four-phase front end
    csr_req_port port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .ack         (ack),
        .rsp         (rsp),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .done        (done),
        .done_rsp    (done_rsp)
    );

    csr_check_stage check_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .cur_priv    (cur_priv),
        .checked     (checked)
    );

    // CSR state and trap handling
    csr_file_stage file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .checked  (checked),
        .mtip     (mtip),
        .cur_priv (cur_priv),
        .done     (done),
        .done_rsp (done_rsp)
    );

endmodule

// ==== hdl/csr_file_stage.sv ====
`timescale 1ns/1ps

module csr_file_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::checked_t checked,
    input  logic               mtip,
    output csr_pkg::priv_e     cur_priv,
    output logic               done,
    output pipe_pkg::csr_rsp_t done_rsp
);

    // Architectural state
    logic           mstatus_mie;
    logic           mstatus_mpie;
    csr_pkg::priv_e mstatus_mpp;
    logic           mie_mtie;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mscratch;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t mcause;
    csr_pkg::xlen_t mtval;

    csr_pkg::xlen_t     mstatus_rd;
    csr_pkg::xlen_t     mie_rd;
    csr_pkg::xlen_t     mip_rd;
    csr_pkg::xlen_t     rdata_old;
    csr_pkg::xlen_t     wdata;
    csr_pkg::xlen_t     trap_cause;
    csr_pkg::xlen_t     mtvec_base;
    csr_pkg::xlen_t     trap_pc;
    logic               is_rw;
    logic               is_mret;
    logic               intr_pending;
    logic               take_trap;
    pipe_pkg::csr_rsp_t rsp_next;

    // Register views of the partially implemented CSRs
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[csr_pkg::MSTATUS_MIE_BIT]        = mstatus_mie;
        mstatus_rd[csr_pkg::MSTATUS_MPIE_BIT]       = mstatus_mpie;
        mstatus_rd[csr_pkg::MSTATUS_MPP_LSB +: 2]   = mstatus_mpp;
        mie_rd = '0;
        mie_rd[csr_pkg::MTIP_BIT] = mie_mtie;
        mip_rd = '0;
        mip_rd[csr_pkg::MTIP_BIT] = mtip;
    end

    always_comb begin
        case (checked.req.addr)
            csr_pkg::ADDR_MSTATUS:  rdata_old = mstatus_rd;
            csr_pkg::ADDR_MISA:     rdata_old = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MIE:      rdata_old = mie_rd;
            csr_pkg::ADDR_MTVEC:    rdata_old = mtvec;
            csr_pkg::ADDR_MSCRATCH: rdata_old = mscratch;
            csr_pkg::ADDR_MEPC:     rdata_old = mepc;
            csr_pkg::ADDR_MCAUSE:   rdata_old = mcause;
            csr_pkg::ADDR_MTVAL:    rdata_old = mtval;
            csr_pkg::ADDR_MIP:      rdata_old = mip_rd;
            default:                rdata_old = '0;
        endcase
    end

    always_comb begin
        case (checked.req.cmd)
            csr_pkg::CSR_W: wdata = checked.req.operand;
            csr_pkg::CSR_S: wdata = rdata_old | checked.req.operand;
            csr_pkg::CSR_C: wdata = rdata_old & ~checked.req.operand;
            default:        wdata = rdata_old;
        endcase
    end

    assign is_rw   = checked.req.cmd inside {csr_pkg::CSR_W, csr_pkg::CSR_S, csr_pkg::CSR_C};
    assign is_mret = checked.req.cmd == csr_pkg::CSR_MRET;

    // Timer interrupt is always enabled below M-mode
    assign intr_pending = mtip && mie_mtie && (cur_priv == csr_pkg::U_MODE || mstatus_mie);
    assign take_trap    = checked.exc || intr_pending;
    assign trap_cause   = checked.exc ? checked.cause : csr_pkg::CAUSE_MACHINE_TIMER_INTERRUPT;

    // Vectored mode offsets interrupts only; the interrupt bit shifts out
    assign mtvec_base = {mtvec[csr_pkg::XLEN-1:2], 2'b00};
    assign trap_pc    = (!checked.exc && mtvec[1:0] == csr_pkg::MTVEC_VECTORED)
                        ? mtvec_base + {trap_cause[csr_pkg::XLEN-3:0], 2'b00}
                        : mtvec_base;

    always_comb begin
        rsp_next.rdata = is_rw ? rdata_old : '0;
        rsp_next.trap  = take_trap;
        if (take_trap) begin
            rsp_next.next_pc = trap_pc;
            rsp_next.priv    = csr_pkg::M_MODE;
        end else if (is_mret) begin
            rsp_next.next_pc = mepc;
            rsp_next.priv    = mstatus_mpp;
        end else begin
            rsp_next.next_pc = checked.req.pc + csr_pkg::xlen_t'(4);
            rsp_next.priv    = cur_priv;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_priv     <= csr_pkg::M_MODE;
            done         <= 1'b0;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= csr_pkg::U_MODE;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else begin
            done <= checked.valid;
            if (checked.valid) begin
                if (take_trap) begin
                    // Trap entry drops an interrupted command
                    mepc         <= checked.req.pc;
                    mcause       <= trap_cause;
                    mtval        <= '0;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= cur_priv;
                    cur_priv     <= csr_pkg::M_MODE;
                end else if (is_mret) begin
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                    cur_priv     <= mstatus_mpp;
                    mstatus_mpp  <= csr_pkg::U_MODE;
                end else if (is_rw) begin
                    case (checked.req.addr)
                        csr_pkg::ADDR_MSTATUS: begin
                            mstatus_mie  <= wdata[csr_pkg::MSTATUS_MIE_BIT];
                            mstatus_mpie <= wdata[csr_pkg::MSTATUS_MPIE_BIT];
                            // Only U and M are legal in MPP
                            mstatus_mpp  <= (wdata[csr_pkg::MSTATUS_MPP_LSB +: 2] == 2'b11)
                                            ? csr_pkg::M_MODE : csr_pkg::U_MODE;
                        end
                        csr_pkg::ADDR_MIE:      mie_mtie <= wdata[csr_pkg::MTIP_BIT];
                        csr_pkg::ADDR_MTVEC:    mtvec    <= wdata;
                        csr_pkg::ADDR_MSCRATCH: mscratch <= wdata;
                        csr_pkg::ADDR_MEPC:     mepc     <= {wdata[csr_pkg::XLEN-1:2], 2'b00};
                        csr_pkg::ADDR_MCAUSE:   mcause   <= wdata;
                        csr_pkg::ADDR_MTVAL:    mtval    <= wdata;
                        // misa and mip are read-only here
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (checked.valid) begin
            done_rsp <= rsp_next;
        end
    end

endmodule

// ==== hdl/csr_check_stage.sv ====
`timescale 1ns/1ps

module csr_check_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  pipe_pkg::csr_req_t issue_req,
    input  csr_pkg::priv_e     cur_priv,
    output pipe_pkg::checked_t checked
);

    logic           is_rw;
    logic           rw_illegal;
    logic           mret_illegal;
    logic           exc;
    csr_pkg::xlen_t cause;

    always_comb begin
        is_rw = issue_req.cmd inside {csr_pkg::CSR_W, csr_pkg::CSR_S, csr_pkg::CSR_C};

        // Address bits 9:8 give the lowest mode allowed to touch the CSR
        rw_illegal   = is_rw && (issue_req.addr[9:8] > cur_priv);
        mret_illegal = issue_req.cmd == csr_pkg::CSR_MRET && cur_priv == csr_pkg::U_MODE;

        exc   = 1'b0;
        cause = '0;
        if (rw_illegal || mret_illegal) begin
            exc   = 1'b1;
            cause = csr_pkg::CAUSE_ILLEGAL_INSTRUCTION;
        end else if (issue_req.cmd == csr_pkg::CSR_ECALL) begin
            exc   = 1'b1;
            cause = (cur_priv == csr_pkg::U_MODE) ? csr_pkg::CAUSE_ECALL_U
                                                  : csr_pkg::CAUSE_ECALL_M;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            checked.valid <= 1'b0;
        end else begin
            checked.valid <= issue_valid;
        end
    end

    // Payload of the checked item
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            checked.req   <= issue_req;
            checked.exc   <= exc;
            checked.cause <= cause;
        end
    end

endmodule

// ==== hdl/csr_req_port.sv ====
`timescale 1ns/1ps

module csr_req_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  pipe_pkg::csr_req_t cmd,
    output logic               ack,
    output pipe_pkg::csr_rsp_t rsp,
    output logic               issue_valid,
    output pipe_pkg::csr_req_t issue_req,
    input  logic               done,
    input  pipe_pkg::csr_rsp_t done_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        HOLD
    } state_e;

    state_e             state;
    logic               issue_pend;
    pipe_pkg::csr_rsp_t rsp_q;

    // Handshake sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            issue_pend  <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            // Request goes out one cycle after capture
            issue_valid <= issue_pend;
            issue_pend  <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        state      <= BUSY;
                        issue_pend <= 1'b1;
                    end
                end
                BUSY: begin
                    if (done) begin
                        state <= req ? HOLD : IDLE;
                    end
                end
                HOLD: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Captured request and held response
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            issue_req <= cmd;
        end
        if (state == BUSY && done) begin
            rsp_q <= done_rsp;
        end
    end

    // ack follows done in the same cycle
    assign ack = (state == BUSY && done) || state == HOLD;
    assign rsp = done ? done_rsp : rsp_q;

endmodule

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

    // One CSR-type instruction as issued by the core
    typedef struct packed {
        csr_pkg::csr_cmd_e  cmd;
        csr_pkg::csr_addr_t addr;
        csr_pkg::xlen_t     operand;
        csr_pkg::xlen_t     pc;
    } csr_req_t;

    // Output of the check stage
    typedef struct packed {
        logic           valid;
        csr_req_t       req;
        logic           exc;
        csr_pkg::xlen_t cause;
    } checked_t;

    // Result returned to the requester
    typedef struct packed {
        csr_pkg::xlen_t rdata;
        logic           trap;
        csr_pkg::xlen_t next_pc;
        csr_pkg::priv_e priv;
    } csr_rsp_t;

endpackage

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    // Architectural widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Privilege levels kept by this unit
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_e;

    // Commands carried by a request
    typedef enum logic [2:0] {
        CSR_NOP   = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Machine trap setup
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    // Exception and interrupt causes
    localparam xlen_t CAUSE_ILLEGAL_INSTRUCTION     = 32'd2;
    localparam xlen_t CAUSE_ECALL_U                 = 32'd8;
    localparam xlen_t CAUSE_ECALL_M                 = 32'd11;
    localparam xlen_t CAUSE_MACHINE_TIMER_INTERRUPT = 32'h8000_0007;

    // RV32 with A, I and M
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

    // Field positions in mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // Timer bit shared by mip.MTIP and mie.MTIE
    localparam int MTIP_BIT = 7;

    // mtvec mode field
    localparam logic [1:0] MTVEC_VECTORED = 2'b01;

endpackage
